/* src/isa_pkg.sv */
// integer slice ISA: sixteen 64-bit registers plus a 4-bit flag register
// opcodes 10..15 are reserved and execute as no-ops that still complete
package isa_pkg;

  localparam int xlen       = 64;
  localparam int reg_count  = 16;
  localparam int shamt_bits = 6;   // shift count taken from b[5:0]
  localparam int imm_bits   = 11;

  typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_shl  = 4'd5,
    op_shr  = 4'd6,
    op_sar  = 4'd7,
    op_movi = 4'd8,   // b already holds the sign-extended imm
    op_sxt  = 4'd9
  } opcode_t;

  // condition codes, evaluated against the flag register before execute
  typedef enum logic [3:0] {
    cc_eq = 4'd0,    // z
    cc_ne = 4'd1,
    cc_cs = 4'd2,    // c
    cc_cc = 4'd3,
    cc_mi = 4'd4,    // n
    cc_pl = 4'd5,
    cc_vs = 4'd6,    // v
    cc_vc = 4'd7,
    cc_hi = 4'd8,    // c and not z
    cc_ls = 4'd9,
    cc_ge = 4'd10,   // n == v
    cc_lt = 4'd11,
    cc_gt = 4'd12,   // not z and n == v
    cc_le = 4'd13,
    cc_al = 4'd14,
    cc_nv = 4'd15
  } cond_t;

  typedef struct packed {
    logic c;
    logic v;
    logic n;
    logic z;
  } flags_t;

  // 32-bit instruction word as written to the command address
  typedef struct packed {
    opcode_t              opcode;
    cond_t                cond;
    reg_idx_t             dst;
    reg_idx_t             srca;
    reg_idx_t             srcb;
    logic                 use_imm;  // replace srcb operand with imm
    logic [imm_bits-1:0]  imm;      // two's complement
  } insn_t;

endpackage

/* src/bus_pkg.sv */
// Wishbone classic slave view: 8-bit byte address, 32-bit data
// register n low word at 8n, high word at 8n+4; adr[1:0] ignored there
package bus_pkg;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // address map
  localparam logic [7:0] adr_reg_base = 8'h00;
  localparam logic [7:0] adr_reg_span = 8'h80;   // 16 regs x 8 bytes
  localparam logic [7:0] adr_flags    = 8'h80;   // flags in bits 3:0
  localparam logic [7:0] adr_cmd      = 8'h84;   // write issues insn, read is zero

  // cycles from first sampled strobe to sampled ack for a command
  localparam int cmd_latency = 4;

endpackage

/* src/reg_file.sv */
// 16 x 64-bit registers and flags, all cleared by reset
// host and execute writes are assumed never to fall in the same cycle
module reg_file import isa_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  // host side, 32-bit halves
  input  logic            host_we,
  input  reg_idx_t        host_idx,
  input  logic            host_hi,
  input  logic [31:0]     host_wdat,
  input  logic            flags_we,
  output logic [31:0]     host_rdat,
  // execute read ports
  input  reg_idx_t        rd_a,
  input  reg_idx_t        rd_b,
  output logic [xlen-1:0] op_a,
  output logic [xlen-1:0] op_b,
  output flags_t          flags,
  // execute writeback
  input  logic            wb_we,
  input  reg_idx_t        wb_idx,
  input  logic [xlen-1:0] wb_dat,
  input  logic            wb_flags_we,
  input  flags_t          wb_flags
);

  logic [xlen-1:0] regs [reg_count];
  flags_t          flags_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_count; i++) regs[i] <= '0;
      flags_q <= '0;
    end else begin
      if (host_we) begin
        if (host_hi) regs[host_idx][xlen-1:32] <= host_wdat;
        else         regs[host_idx][31:0]      <= host_wdat;
      end
      if (flags_we) flags_q <= flags_t'(host_wdat[3:0]);
      if (wb_we) regs[wb_idx] <= wb_dat;
      if (wb_flags_we) flags_q <= wb_flags;
    end
  end

  assign op_a  = regs[rd_a];
  assign op_b  = regs[rd_b];
  assign flags = flags_q;

  assign host_rdat = host_hi ? regs[host_idx][xlen-1:32] : regs[host_idx][31:0];

endmodule

/* src/int_alu.sv */
// purely combinational 64-bit integer ALU
// reserved opcodes give a zero result; only add/sub produce c and v
module int_alu import isa_pkg::*; (
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  opcode_t         op,
  output logic [xlen-1:0] res,
  output flags_t          res_flags
);

  logic                  is_sub;
  logic                  arith;
  logic [xlen-1:0]       b_eff;
  logic [xlen:0]         sum;      // msb is carry out of bit 63
  logic [shamt_bits-1:0] shamt;
  logic [xlen-1:0]       sxt_val;

  assign is_sub = (op == op_sub);
  assign arith  = (op == op_add) || is_sub;
  assign b_eff  = is_sub ? ~b : b;

  // a + ~b + 1 for sub, so carry set means no borrow
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {{xlen{1'b0}}, is_sub};
  assign shamt = b[shamt_bits-1:0];

  always_comb begin
    case (b[1:0])
      2'd0:    sxt_val = {{(xlen-8){a[7]}}, a[7:0]};
      2'd1:    sxt_val = {{(xlen-16){a[15]}}, a[15:0]};
      2'd2:    sxt_val = {{(xlen-32){a[31]}}, a[31:0]};
      default: sxt_val = a;   // full width, unchanged
    endcase
  end

  always_comb begin
    case (op)
      op_add,
      op_sub:  res = sum[xlen-1:0];
      op_and:  res = a & b;
      op_or:   res = a | b;
      op_xor:  res = a ^ b;
      op_shl:  res = a << shamt;
      op_shr:  res = a >> shamt;
      op_sar:  res = $signed(a) >>> shamt;
      op_movi: res = b;
      op_sxt:  res = sxt_val;
      default: res = '0;
    endcase
  end

  always_comb begin
    res_flags.n = res[xlen-1];
    res_flags.z = (res == '0);
    res_flags.c = arith & sum[xlen];
    // signed overflow: same-sign inputs, result sign differs
    res_flags.v = arith & (a[xlen-1] == b_eff[xlen-1]) & (res[xlen-1] != a[xlen-1]);
  end

endmodule

/* src/exec_pipe.sv */
// two-stage execute: operand/condition stage, then ALU result and writeback
// insn must stay stable from start until done; one command in flight
module exec_pipe import isa_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  insn_t           insn,
  output logic            done,
  output reg_idx_t        rd_a,
  output reg_idx_t        rd_b,
  input  logic [xlen-1:0] op_a,
  input  logic [xlen-1:0] op_b,
  input  flags_t          flags,
  output logic            wb_we,
  output reg_idx_t        wb_idx,
  output logic [xlen-1:0] wb_dat,
  output logic            wb_flags_we,
  output flags_t          wb_flags
);

  typedef struct packed {
    opcode_t         op;
    reg_idx_t        dst;
    logic            commit;   // condition taken and opcode defined
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } s1_t;

  typedef struct packed {
    reg_idx_t        dst;
    logic [xlen-1:0] dat;
    flags_t          fl;
  } s2_t;

  function automatic logic cond_met(cond_t cc, flags_t f);
    logic r;
    case (cc)
      cc_eq:   r = f.z;
      cc_ne:   r = !f.z;
      cc_cs:   r = f.c;
      cc_cc:   r = !f.c;
      cc_mi:   r = f.n;
      cc_pl:   r = !f.n;
      cc_vs:   r = f.v;
      cc_vc:   r = !f.v;
      cc_hi:   r = f.c && !f.z;
      cc_ls:   r = !(f.c && !f.z);
      cc_ge:   r = (f.n == f.v);
      cc_lt:   r = (f.n != f.v);
      cc_gt:   r = !f.z && (f.n == f.v);
      cc_le:   r = !(!f.z && (f.n == f.v));
      cc_al:   r = 1'b1;
      default: r = 1'b0;   // cc_nv
    endcase
    return r;
  endfunction

  logic            s1_valid, s2_valid, s2_wr;
  s1_t             s1;
  s2_t             s2;
  logic [xlen-1:0] imm_ext;
  logic [xlen-1:0] alu_res;
  flags_t          alu_flags;

  assign rd_a    = insn.srca;
  assign rd_b    = insn.srcb;
  assign imm_ext = {{(xlen-imm_bits){insn.imm[imm_bits-1]}}, insn.imm};

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s2_wr    <= 1'b0;
    end else begin
      s1_valid <= start;
      s2_valid <= s1_valid;
      s2_wr    <= s1_valid & s1.commit;
    end
    s1.op     <= insn.opcode;
    s1.dst    <= insn.dst;
    s1.commit <= cond_met(insn.cond, flags) && (insn.opcode <= op_sxt);
    s1.a      <= op_a;
    s1.b      <= insn.use_imm ? imm_ext : op_b;
    s2.dst    <= s1.dst;
    s2.dat    <= alu_res;
    s2.fl     <= alu_flags;
  end

  int_alu alu_i (
    .a         (s1.a),
    .b         (s1.b),
    .op        (s1.op),
    .res       (alu_res),
    .res_flags (alu_flags)
  );

  assign done        = s2_valid;
  assign wb_we       = s2_wr;
  assign wb_flags_we = s2_wr;   // flags follow the result
  assign wb_idx      = s2.dst;
  assign wb_dat      = s2.dat;
  assign wb_flags    = s2.fl;

endmodule

/* src/wb_slave_port.sv */
// Wishbone classic slave: register/flag access acks one cycle after strobe
// a command write holds the bus until the execute pipe reports done
module wb_slave_port import isa_pkg::*; import bus_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  wb_req_t     wb_req,
  output wb_rsp_t     wb_rsp,
  // register file host port
  output logic        host_we,
  output reg_idx_t    host_idx,
  output logic        host_hi,
  output logic [31:0] host_wdat,
  output logic        flags_we,
  input  logic [31:0] host_rdat,
  input  flags_t      flags,
  // execute pipe
  output logic        start,
  output insn_t       insn,
  input  logic        done
);

  logic        accept;
  logic        sel_reg, sel_flags, sel_cmd;
  logic        cmd_wr;
  logic [7:0]  reg_off;
  logic [31:0] rdat_d;
  logic [31:0] rdat_q;
  logic        ack_q;
  logic        busy_q;
  logic        start_q;
  insn_t       insn_q;

  // ack_q blocks a second accept of the same held transfer
  assign accept = wb_req.cyc & wb_req.stb & ~ack_q & ~busy_q;

  assign reg_off   = wb_req.adr - adr_reg_base;
  assign sel_reg   = (reg_off < adr_reg_span);
  assign sel_flags = (wb_req.adr == adr_flags);
  assign sel_cmd   = (wb_req.adr == adr_cmd);
  assign cmd_wr    = sel_cmd & wb_req.we;

  assign host_idx  = reg_off[6:3];
  assign host_hi   = reg_off[2];
  assign host_wdat = wb_req.dat;
  assign host_we   = accept & wb_req.we & sel_reg;
  assign flags_we  = accept & wb_req.we & sel_flags;

  // unmapped and command reads return zero
  always_comb begin
    rdat_d = '0;
    if (sel_reg)        rdat_d = host_rdat;
    else if (sel_flags) rdat_d = {28'h0, flags};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q   <= 1'b0;
      busy_q  <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= accept & cmd_wr;
      ack_q   <= (accept & ~cmd_wr) | done;   // command acks after done
      if (accept & cmd_wr) busy_q <= 1'b1;
      else if (done)       busy_q <= 1'b0;
    end
    if (accept) rdat_q <= rdat_d;
    if (accept & cmd_wr) insn_q <= insn_t'(wb_req.dat);
  end

  assign start = start_q;
  assign insn  = insn_q;

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rdat_q;

endmodule

/* src/exec_top.sv */
// execute slice top: Wishbone port, register file and execute pipe
module exec_top import isa_pkg::*; import bus_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  logic            host_we, host_hi, flags_we;
  reg_idx_t        host_idx;
  logic [31:0]     host_wdat, host_rdat;
  logic            start, done;
  insn_t           insn;
  reg_idx_t        rd_a, rd_b, wb_idx;
  logic [xlen-1:0] op_a, op_b, wb_dat;
  flags_t          flags, wb_flags;
  logic            wb_we, wb_flags_we;

  wb_slave_port port_i (
    .clk, .rst, .wb_req, .wb_rsp,
    .host_we, .host_idx, .host_hi, .host_wdat, .flags_we, .host_rdat,
    .flags, .start, .insn, .done
  );

  reg_file rf_i (
    .clk, .rst,
    .host_we, .host_idx, .host_hi, .host_wdat, .flags_we, .host_rdat,
    .rd_a, .rd_b, .op_a, .op_b, .flags,
    .wb_we, .wb_idx, .wb_dat, .wb_flags_we, .wb_flags
  );

  exec_pipe pipe_i (
    .clk, .rst, .start, .insn, .done,
    .rd_a, .rd_b, .op_a, .op_b, .flags,
    .wb_we, .wb_idx, .wb_dat, .wb_flags_we, .wb_flags
  );

endmodule

/* tb/exec_sva.sv */
// Wishbone ack checks, bound into every wb_slave_port instance
// assumes the master holds cyc and stb until it samples ack
module exec_sva (
  input logic clk,
  input logic rst,
  input logic cyc,
  input logic stb,
  input logic ack
);

  int fail_count = 0;   // failed assertions so far

  // ack only answers a live strobe
  ack_needs_strobe: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> cyc && stb)
    else begin
      $error("ack rose without cyc and stb");
      fail_count++;
    end

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
    ack |=> !ack)
    else begin
      $error("ack stayed high for two cycles");
      fail_count++;
    end

  ack_low_after_reset: assert property (@(posedge clk) rst |=> !ack)
    else begin
      $error("ack high in the cycle after reset");
      fail_count++;
    end

endmodule

bind wb_slave_port exec_sva sva_i (
  .clk (clk),
  .rst (rst),
  .cyc (wb_req.cyc),
  .stb (wb_req.stb),
  .ack (wb_rsp.ack)
);

/* tb/exec_tb.sv */
// directed tests of the execute slice through its Wishbone port
// ack is sampled at the falling edge; r1, r2 are sources and r3 the dst of every insn
module exec_tb import isa_pkg::*; import bus_pkg::*; ();

  logic    clk;
  logic    rst;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  integer  seed;

  exec_top exec_top_i (.clk, .rst, .wb_req, .wb_rsp);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // stop at the first failed bus protocol assertion
  always @(posedge clk) begin
    if (exec_top_i.port_i.sva_i.fail_count != 0) begin
      $display("Done: errors found");
      $fatal(1, "a bus protocol assertion failed");
    end
  end

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic flags_t rand_flags();
    return flags_t'(4'($random(seed)));
  endfunction

  task automatic expect_equal(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  task automatic bus_xfer(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                          output logic [31:0] rdat);
    int n;
    int exp_lat;
    n = 0;
    exp_lat = (we && adr == adr_cmd) ? cmd_latency : 1;
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    do begin
      @(negedge clk);
      n++;
      if (n > 16) begin
        $display("bus transfer to address %h never got an ack", adr);
        $display("Done: errors found");
        $fatal(1);
      end
    end while (!wb_rsp.ack);
    rdat = wb_rsp.dat;
    expect_equal($sformatf("ack latency adr %h", adr), exp_lat, n - 1);  // E is drive edge + 1
    @(posedge clk);
    wb_req <= '0;
  endtask

  task automatic reg_write(input int idx, input logic [63:0] val);
    logic [31:0] rd;
    bus_xfer(1'b1, 8'(idx * 8), val[31:0], rd);
    bus_xfer(1'b1, 8'(idx * 8 + 4), val[63:32], rd);
  endtask

  task automatic reg_read(input int idx, output logic [63:0] val);
    bus_xfer(1'b0, 8'(idx * 8), '0, val[31:0]);
    bus_xfer(1'b0, 8'(idx * 8 + 4), '0, val[63:32]);
  endtask

  task automatic flags_write(input flags_t f);
    logic [31:0] rd;
    bus_xfer(1'b1, adr_flags, {28'h0, f}, rd);
  endtask

  task automatic flags_read(output flags_t f);
    logic [31:0] rd;
    bus_xfer(1'b0, adr_flags, '0, rd);
    expect_equal("flags upper bits", 28'h0, rd[31:4]);
    f = flags_t'(rd[3:0]);
  endtask

  function automatic void alu_model(input logic [3:0] op, input logic [63:0] a,
                                    input logic [63:0] b, output logic [63:0] r,
                                    output flags_t f);
    logic [5:0] sh;
    sh = b[5:0];
    f = '0;
    case (op)
      4'd0: begin
        {f.c, r} = {1'b0, a} + {1'b0, b};
        f.v = (a[63] == b[63]) && (r[63] != a[63]);
      end
      4'd1: begin
        r = a - b;
        f.c = (a >= b);   // no borrow
        f.v = (a[63] != b[63]) && (r[63] != a[63]);
      end
      4'd2: r = a & b;
      4'd3: r = a | b;
      4'd4: r = a ^ b;
      4'd5: r = a << sh;
      4'd6: r = a >> sh;
      4'd7: r = 64'($signed(a) >>> sh);
      4'd8: r = b;
      4'd9: begin
        case (b[1:0])
          2'd0:    r = 64'($signed(a[7:0]));
          2'd1:    r = 64'($signed(a[15:0]));
          2'd2:    r = 64'($signed(a[31:0]));
          default: r = a;
        endcase
      end
      default: r = '0;
    endcase
    f.n = r[63];
    f.z = (r == 64'd0);
  endfunction

  // odd codes are the inverse of the even code below them
  function automatic logic cond_model(input logic [3:0] cc, input flags_t f);
    logic base;
    case (cc[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c && !f.z;
      3'd5:    base = (f.n == f.v);
      3'd6:    base = !f.z && (f.n == f.v);
      default: base = 1'b1;
    endcase
    return cc[0] ? !base : base;
  endfunction

  task automatic exec_check(input string name, input logic [3:0] op, input logic [3:0] cc,
                            input logic [63:0] a, input logic [63:0] b, input logic use_imm,
                            input logic [10:0] imm, input flags_t fin);
    logic [63:0] old, bval, exp_res, got;
    flags_t      exp_fl, got_fl;
    logic [31:0] rd;
    old = rand64();
    reg_write(1, a);
    reg_write(2, b);
    reg_write(3, old);
    flags_write(fin);
    bval = use_imm ? {{53{imm[10]}}, imm} : b;
    alu_model(op, a, bval, exp_res, exp_fl);
    if (!cond_model(cc, fin) || op > 4'd9) begin
      exp_res = old;   // nothing written
      exp_fl  = fin;
    end
    bus_xfer(1'b1, adr_cmd, {op, cc, 4'd3, 4'd1, 4'd2, use_imm, imm}, rd);
    reg_read(3, got);
    expect_equal(name, exp_res, got);
    flags_read(got_fl);
    expect_equal({name, " flags"}, exp_fl, got_fl);
  endtask

  task automatic test_registers();
    logic [63:0] vals [16];
    logic [63:0] v;
    logic [31:0] rd;
    flags_t      fl;
    for (int i = 0; i < 16; i++) begin
      reg_read(i, v);
      expect_equal($sformatf("reset r%0d", i), 64'd0, v);
    end
    flags_read(fl);
    expect_equal("reset flags", 4'd0, fl);
    for (int i = 0; i < 16; i++) begin
      vals[i] = rand64();
      reg_write(i, vals[i]);
    end
    fl = rand_flags();
    flags_write(fl);
    bus_xfer(1'b1, 8'hc0, 32'hffff_ffff, rd);   // unmapped, ignored
    for (int i = 0; i < 16; i++) begin
      reg_read(i, v);
      expect_equal($sformatf("readback r%0d", i), vals[i], v);
    end
    flags_read(v[3:0]);
    expect_equal("readback flags", fl, v[3:0]);
    bus_xfer(1'b0, 8'h88, '0, rd);
    expect_equal("unmapped read 88", 32'd0, rd);
    bus_xfer(1'b0, 8'hfc, '0, rd);
    expect_equal("unmapped read fc", 32'd0, rd);
    bus_xfer(1'b0, adr_cmd, '0, rd);
    expect_equal("command read", 32'd0, rd);
  endtask

  task automatic test_add_sub();
    logic [63:0] ea [5];
    logic [63:0] eb [5];
    ea = '{'1, 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000, 0};
    eb = '{64'd1, '1, 64'd1, 64'h8000_0000_0000_0000, 64'd0};
    for (int i = 0; i < 5; i++) begin
      exec_check($sformatf("add edge %0d", i), op_add, cc_al, ea[i], eb[i], 0, '0, '0);
      exec_check($sformatf("sub edge %0d", i), op_sub, cc_al, ea[i], eb[i], 0, '0, '0);
    end
    for (int i = 0; i < 8; i++) begin
      exec_check("add random", op_add, cc_al, rand64(), rand64(), 0, '0, rand_flags());
      exec_check("sub random", op_sub, cc_al, rand64(), rand64(), 0, '0, rand_flags());
    end
  endtask

  task automatic test_logic_shift();
    for (int op = op_and; op <= op_sar; op++) begin
      for (int k = 0; k < 3; k++) begin
        exec_check($sformatf("op %0d reg", op), 4'(op), cc_al, rand64(), rand64(), 1'b0,
                   '0, rand_flags());
        exec_check($sformatf("op %0d imm", op), 4'(op), cc_al, rand64(), rand64(), 1'b1,
                   11'($random(seed)), rand_flags());
      end
    end
  endtask

  task automatic test_movi_sxt();
    logic [10:0] imms [4];
    imms = '{11'h400, 11'h7ff, 11'h3ff, 11'h005};
    foreach (imms[i])
      exec_check($sformatf("movi %h", imms[i]), op_movi, cc_al, rand64(), rand64(), 1'b1,
                 imms[i], rand_flags());
    for (int s = 0; s < 4; s++) begin
      exec_check($sformatf("sxt reg sel %0d", s), op_sxt, cc_al, 64'h0123_4567_89ab_cdef,
                 64'(s), 1'b0, '0, rand_flags());
      exec_check($sformatf("sxt imm sel %0d", s), op_sxt, cc_al, 64'h8654_3210_7edc_5a7b,
                 rand64(), 1'b1, 11'(s), rand_flags());
    end
  endtask

  task automatic test_conditions();
    for (int f = 0; f < 16; f++)
      for (int cc = 0; cc < 16; cc++)
        exec_check($sformatf("cond %0d flags %h", cc, f), op_add, 4'(cc), rand64(), rand64(),
                   1'b0, '0, flags_t'(4'(f)));
    for (int op = 10; op < 16; op++)
      exec_check($sformatf("reserved op %0d", op), 4'(op), cc_al, rand64(), rand64(), 1'b0,
                 '0, rand_flags());
  endtask

  initial begin
    seed   = 90;
    rst    = 1'b1;
    wb_req = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    test_registers();
    test_add_sub();
    test_logic_shift();
    test_movi_sxt();
    test_conditions();   // command and register ack latency checked in every transfer
    @(negedge clk);
    if (exec_top_i.port_i.sva_i.fail_count != 0) begin
      $display("Done: errors found");
      $fatal(1, "a bus protocol assertion failed");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

/* build.f */
src/isa_pkg.sv
src/bus_pkg.sv
src/reg_file.sv
src/int_alu.sv
src/exec_pipe.sv
src/wb_slave_port.sv
src/exec_top.sv
tb/exec_sva.sv
tb/exec_tb.sv

/* Bender.yml */
package:
  name: exec_slice

sources:
  - files:
      - src/isa_pkg.sv
      - src/bus_pkg.sv
      - src/reg_file.sv
      - src/int_alu.sv
      - src/exec_pipe.sv
      - src/wb_slave_port.sv
      - src/exec_top.sv
  - target: test
    files:
      - tb/exec_sva.sv
      - tb/exec_tb.sv
